//--- list.f
+incdir+design
design/apb_bridge_pkg.sv
design/iob2apb.sv
design/apb_decoder.sv
design/apb_regbank.sv
design/apb_subsys_top.sv
verification/apb_subsys_tb.sv

//--- Bender.yml
package:
  name: apb_subsys

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/apb_bridge_pkg.sv
      - design/iob2apb.sv
      - design/apb_decoder.sv
      - design/apb_regbank.sv
      - design/apb_subsys_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - verification/apb_subsys_tb.sv

//--- verification/apb_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_settings.svh"

module apb_subsys_tb;

   import apb_bridge_pkg::*;

   localparam int RST_CYCLES = 16;
   localparam int MAX_WAIT   = (`BANK0_WAIT > `BANK1_WAIT) ? `BANK0_WAIT : `BANK1_WAIT;
   localparam int MAX_HOLD   = 4;             // Longest rready delay in the table
   localparam int HS_LIMIT   = 4 + MAX_WAIT;  // Cycles allowed for one handshake

   typedef struct {
      string             name;
      bit                wr;
      logic [ADDR_W-1:0] addr;
      logic [STRB_W-1:0] strb;
      logic [DATA_W-1:0] data;      // Write data, or expected read data
      bit                rnd;       // Write data drawn at random
      int                hold;      // Cycles of low rready where a negative value picks 0 to 3
      bit                use_ref;   // Expected read data from the reference memory
   } test_t;

   logic     clk_i;
   logic     rst_n_i;
   iob_req_t req;
   iob_rsp_t rsp;

   test_t             tests[$];
   bit                table_ready;
   logic [DATA_W-1:0] ref_mem [2][`REGBANK_DEPTH];   // One image per bank

   apb_subsys_top dut (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .iob_req_i(req),
      .iob_rsp_o(rsp)
   );

   always #5 clk_i = ~clk_i;

   function automatic int bank_of(logic [ADDR_W-1:0] addr);
      return int'(addr[ADDR_W-1]);   // Top address bit picks the bank
   endfunction

   function automatic int word_of(logic [ADDR_W-1:0] addr);
      int word;
      word = int'(addr[ADDR_W-2:0]) / STRB_W;
      return word % `REGBANK_DEPTH;
   endfunction

   function automatic int exp_latency(logic [ADDR_W-1:0] addr);
      return (bank_of(addr) == 1) ? 1 + `BANK1_WAIT : 1 + `BANK0_WAIT;
   endfunction

   // Enabled byte lanes take the new data, the others keep the old word
   function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_word,
                                                     logic [DATA_W-1:0] wdata,
                                                     logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return result;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Run stopped after a failed check");
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         stop_run($sformatf("Error: test %s, %s: expected 0x%08h, actual 0x%08h",
                            test, what, expected, actual));
      end
   endtask

   task automatic add_test(input string name, input bit wr, input logic [ADDR_W-1:0] addr,
                           input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] data,
                           input bit rnd, input int hold, input bit use_ref);
      test_t t;
      t.name    = name;
      t.wr      = wr;
      t.addr    = addr;
      t.strb    = strb;
      t.data    = data;
      t.rnd     = rnd;
      t.hold    = hold;
      t.use_ref = use_ref;
      tests.push_back(t);
   endtask

   task automatic build_table();
      //       name            wr    addr     strb  data          rnd   hold ref
      add_test("rd_b0_reset",  1'b0, 12'h004, 4'h0, 32'h0000_0000, 1'b0, -1, 1'b0);
      add_test("rd_b1_reset",  1'b0, 12'h804, 4'h0, 32'h0000_0000, 1'b0, -1, 1'b0);
      add_test("wr_b0_full",   1'b1, 12'h008, 4'hf, 32'h1234_5678, 1'b0, -1, 1'b0);
      add_test("rd_b0_full",   1'b0, 12'h008, 4'h0, 32'h1234_5678, 1'b0, -1, 1'b0);
      add_test("wr_b1_full",   1'b1, 12'h808, 4'hf, 32'hcafe_f00d, 1'b0, -1, 1'b0);
      add_test("rd_b1_full",   1'b0, 12'h808, 4'h0, 32'hcafe_f00d, 1'b0, -1, 1'b0);
      add_test("rd_b0_indep",  1'b0, 12'h008, 4'h0, 32'h1234_5678, 1'b0, -1, 1'b0);
      add_test("wr_b0_part",   1'b1, 12'h008, 4'h5, 32'haabb_ccdd, 1'b0, -1, 1'b0);
      add_test("rd_b0_part",   1'b0, 12'h008, 4'h0, 32'h12bb_56dd, 1'b0, -1, 1'b0);
      add_test("wr_b1_part",   1'b1, 12'h808, 4'ha, 32'h1122_3344, 1'b0, -1, 1'b0);
      add_test("rd_b1_part",   1'b0, 12'h808, 4'h0, 32'h11fe_330d, 1'b0, -1, 1'b0);
      add_test("wr_b0_rnd",    1'b1, 12'h03c, 4'hf, 32'h0000_0000, 1'b1, -1, 1'b0);
      add_test("wr_b1_rnd",    1'b1, 12'h83c, 4'hf, 32'h0000_0000, 1'b1, -1, 1'b0);
      add_test("rd_b0_rnd",    1'b0, 12'h03c, 4'h0, 32'h0000_0000, 1'b0, -1, 1'b1);
      add_test("rd_b1_hold",   1'b0, 12'h83c, 4'h0, 32'h0000_0000, 1'b0,  3, 1'b1);
      add_test("wr_b1_wrap",   1'b1, 12'h848, 4'h3, 32'h0000_0000, 1'b1, -1, 1'b0);
      add_test("rd_b1_wrap",   1'b0, 12'h808, 4'h0, 32'h0000_0000, 1'b0,  4, 1'b1);
      add_test("rd_b0_hold",   1'b0, 12'h008, 4'h0, 32'h12bb_56dd, 1'b0,  3, 1'b0);
   endtask

   // Counts rising edges up to and including the one with ready high
   task automatic wait_ready(input string test, output int lat);
      lat = 1;
      @(posedge clk_i);
      while (!rsp.ready) begin
         lat++;
         if (lat > HS_LIMIT) begin
            stop_run($sformatf("Timeout: no ready for test %s", test));
         end
         @(posedge clk_i);
      end
   endtask

   task automatic run_write(input test_t t);
      logic [DATA_W-1:0] wdata;
      int                lat;
      int                bank;
      int                word;
      wdata = t.rnd ? $urandom : t.data;
      bank  = bank_of(t.addr);
      word  = word_of(t.addr);
      @(negedge clk_i);
      req.valid  = 1'b1;
      req.addr   = t.addr;
      req.wdata  = wdata;
      req.wstrb  = t.strb;
      req.rready = 1'b0;
      wait_ready(t.name, lat);
      check_value(t.name, "ready latency", DATA_W'(exp_latency(t.addr)), DATA_W'(lat));
      ref_mem[bank][word] = merge_bytes(ref_mem[bank][word], wdata, t.strb);
      @(negedge clk_i);
      req.valid = 1'b0;
      req.wstrb = '0;
      repeat (2) begin
         @(posedge clk_i);
         check_value(t.name, "rvalid after write", '0, DATA_W'(rsp.rvalid));
      end
   endtask

   task automatic run_read(input test_t t);
      logic [DATA_W-1:0] expected;
      int                lat;
      int                hold;
      int                cycles;
      expected = t.use_ref ? ref_mem[bank_of(t.addr)][word_of(t.addr)] : t.data;
      hold     = (t.hold < 0) ? int'($urandom % 4) : t.hold;
      @(negedge clk_i);
      req.valid  = 1'b1;
      req.addr   = t.addr;
      req.wdata  = '0;
      req.wstrb  = '0;
      req.rready = 1'b0;
      wait_ready(t.name, lat);
      check_value(t.name, "ready latency", DATA_W'(exp_latency(t.addr)), DATA_W'(lat));
      @(negedge clk_i);
      req.valid  = 1'b0;
      req.rready = (hold == 0);
      cycles = 0;
      @(posedge clk_i);
      while (!rsp.rvalid) begin
         cycles++;
         if (cycles > HS_LIMIT) begin
            stop_run($sformatf("Timeout: no rvalid for test %s", t.name));
         end
         @(posedge clk_i);
      end
      check_value(t.name, "rvalid delay after ready", '0, DATA_W'(cycles));
      for (int i = 0; i < hold; i++) begin
         check_value(t.name, "rvalid while held", DATA_W'(1), DATA_W'(rsp.rvalid));
         check_value(t.name, "rdata while held", expected, rsp.rdata);
         check_value(t.name, "ready while held", '0, DATA_W'(rsp.ready));
         @(negedge clk_i);
         if (i == 0 && hold >= 2) begin
            // Request to the other bank must stall until the data is taken
            req.valid = 1'b1;
            req.addr  = {~t.addr[ADDR_W-1], t.addr[ADDR_W-2:0]};
         end
         if (i == hold - 1) begin
            req.valid  = 1'b0;
            req.rready = 1'b1;
         end
         @(posedge clk_i);
      end
      check_value(t.name, "rvalid at rready", DATA_W'(1), DATA_W'(rsp.rvalid));
      check_value(t.name, "rdata", expected, rsp.rdata);
      @(negedge clk_i);
      req.rready = 1'b0;
      @(posedge clk_i);
      check_value(t.name, "rvalid after rready", '0, DATA_W'(rsp.rvalid));
   endtask

   initial begin : watchdog
      int limit_cycles;
      wait (table_ready);
      limit_cycles = RST_CYCLES + 4 + tests.size() * (4 + MAX_WAIT + MAX_HOLD);
      repeat (limit_cycles) @(posedge clk_i);
      stop_run($sformatf("Timeout: tests still running after %0d cycles", limit_cycles));
   end

   initial begin : main
      clk_i       = 1'b0;
      rst_n_i     = 1'b0;
      req         = '0;
      table_ready = 1'b0;
      void'($urandom(32'hab65686d));
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < `REGBANK_DEPTH; w++) begin
            ref_mem[b][w] = '0;
         end
      end
      build_table();
      table_ready = 1'b1;

      repeat (RST_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      // Idle bus right after reset
      @(posedge clk_i);
      check_value("idle_after_reset", "rvalid", '0, DATA_W'(rsp.rvalid));
      check_value("idle_after_reset", "ready", '0, DATA_W'(rsp.ready));
      check_value("idle_after_reset", "rdata", '0, rsp.rdata);

      foreach (tests[i]) begin
         if (tests[i].wr) begin
            run_write(tests[i]);
         end else begin
            run_read(tests[i]);
         end
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/apb_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_settings.svh"

module apb_subsys_top (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  apb_bridge_pkg::iob_req_t iob_req_i,
   output apb_bridge_pkg::iob_rsp_t iob_rsp_o
);

   import apb_bridge_pkg::*;

   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   apb_req_t bank0_req;
   apb_rsp_t bank0_rsp;
   apb_req_t bank1_req;
   apb_rsp_t bank1_rsp;

   iob2apb u_bridge (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .iob_req_i(iob_req_i),
      .iob_rsp_o(iob_rsp_o),
      .apb_req_o(apb_req),
      .apb_rsp_i(apb_rsp)
   );

   apb_decoder u_decoder (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .apb_req_i  (apb_req),
      .apb_rsp_o  (apb_rsp),
      .bank0_req_o(bank0_req),
      .bank1_req_o(bank1_req),
      .bank0_rsp_i(bank0_rsp),
      .bank1_rsp_i(bank1_rsp)
   );

   // Fast bank at the bottom half of the address space
   apb_regbank #(
      .DEPTH(`REGBANK_DEPTH),
      .WAIT (`BANK0_WAIT)
   ) u_bank0 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .apb_req_i(bank0_req),
      .apb_rsp_o(bank0_rsp)
   );

   apb_regbank #(
      .DEPTH(`REGBANK_DEPTH),
      .WAIT (`BANK1_WAIT)
   ) u_bank1 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .apb_req_i(bank1_req),
      .apb_rsp_o(bank1_rsp)
   );

endmodule

`default_nettype wire

//--- design/apb_regbank.sv
`timescale 1ns/1ps
`default_nettype none

`include "apb_bridge_settings.svh"

module apb_regbank #(
   parameter int DEPTH = `REGBANK_DEPTH,
   parameter int WAIT  = `BANK0_WAIT
) (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  apb_bridge_pkg::apb_req_t apb_req_i,
   output apb_bridge_pkg::apb_rsp_t apb_rsp_o
);

   import apb_bridge_pkg::*;

   localparam int OFFS_W = $clog2(STRB_W);              // Byte offset bits
   localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

   logic [DATA_W-1:0]        mem [DEPTH];
   logic [ADDR_W-OFFS_W-1:0] word_addr;
   logic [IDX_W-1:0]         idx;
   logic [CNT_W-1:0]         wait_cnt;
   logic                     access;
   logic                     ready;

   assign word_addr = apb_req_i.addr[ADDR_W-1:OFFS_W];
   assign idx       = IDX_W'(word_addr % DEPTH);   // Wraps inside the bank

   assign access = apb_req_i.sel & apb_req_i.enable;
   assign ready  = access & (wait_cnt == CNT_W'(WAIT));

   assign apb_rsp_o.ready = ready;
   assign apb_rsp_o.rdata = ready ? mem[idx] : '0;

   // Counts completed access cycles of the current transfer
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wait_cnt <= '0;
      end else if (!access || ready) begin
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int w = 0; w < DEPTH; w++) begin
            mem[w] <= '0;
         end
      end else if (ready && apb_req_i.write) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (apb_req_i.wstrb[b]) begin
               mem[idx][8*b +: 8] <= apb_req_i.wdata[8*b +: 8];   // Byte merge
            end
         end
      end
   end

   a_ready_needs_sel : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_rsp_o.ready |-> apb_req_i.sel
   ) else $error("Bank ready without sel");

endmodule

`default_nettype wire

//--- design/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  apb_bridge_pkg::apb_req_t apb_req_i,
   output apb_bridge_pkg::apb_rsp_t apb_rsp_o,
   output apb_bridge_pkg::apb_req_t bank0_req_o,
   output apb_bridge_pkg::apb_req_t bank1_req_o,
   input  apb_bridge_pkg::apb_rsp_t bank0_rsp_i,
   input  apb_bridge_pkg::apb_rsp_t bank1_rsp_i
);

   import apb_bridge_pkg::*;

   logic              bank_sel;    // High selects bank 1
   logic [ADDR_W-1:0] local_addr;

   assign bank_sel   = apb_req_i.addr[ADDR_W-1];
   assign local_addr = {1'b0, apb_req_i.addr[ADDR_W-2:0]};

   always_comb begin
      bank0_req_o        = apb_req_i;
      bank0_req_o.addr   = local_addr;
      bank0_req_o.sel    = apb_req_i.sel & ~bank_sel;
      bank0_req_o.enable = apb_req_i.enable & ~bank_sel;
   end

   always_comb begin
      bank1_req_o        = apb_req_i;
      bank1_req_o.addr   = local_addr;
      bank1_req_o.sel    = apb_req_i.sel & bank_sel;
      bank1_req_o.enable = apb_req_i.enable & bank_sel;
   end

   // Response from whichever bank the address points at
   assign apb_rsp_o = bank_sel ? bank1_rsp_i : bank0_rsp_i;

   a_one_bank_sel : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(bank0_req_o.sel && bank1_req_o.sel)
   ) else $error("Both banks selected at once");

endmodule

`default_nettype wire

//--- design/iob2apb.sv
`timescale 1ns/1ps
`default_nettype none

module iob2apb (
   input  wire                     clk_i,
   input  wire                     rst_n_i,
   input  apb_bridge_pkg::iob_req_t iob_req_i,
   output apb_bridge_pkg::iob_rsp_t iob_rsp_o,
   output apb_bridge_pkg::apb_req_t apb_req_o,
   input  apb_bridge_pkg::apb_rsp_t apb_rsp_i
);

   import apb_bridge_pkg::*;

   typedef enum logic [1:0] {
      WAIT_VALID  = 2'd0,
      WAIT_READY  = 2'd1,
      WAIT_RREADY = 2'd2
   } state_t;

   state_t            state_q;
   state_t            state_d;
   logic              active;      // Drives both sel and enable
   logic              is_write;
   logic              rvalid_q;
   logic              rvalid_d;
   logic              capture;
   logic [DATA_W-1:0] rdata_q;

   assign is_write = |iob_req_i.wstrb;

   // APB request follows the IOb request directly
   assign apb_req_o.sel    = active;
   assign apb_req_o.enable = active;
   assign apb_req_o.write  = is_write;
   assign apb_req_o.addr   = iob_req_i.addr;
   assign apb_req_o.wdata  = iob_req_i.wdata;
   assign apb_req_o.wstrb  = iob_req_i.wstrb;

   assign iob_rsp_o.ready  = apb_rsp_i.ready;   // Straight through
   assign iob_rsp_o.rvalid = rvalid_q;
   assign iob_rsp_o.rdata  = rdata_q;

   always_comb begin
      state_d  = state_q;
      active   = 1'b0;
      rvalid_d = 1'b0;

      case (state_q)
         WAIT_VALID: begin
            if (iob_req_i.valid) begin
               active = 1'b1;
               if (!apb_rsp_i.ready) begin
                  state_d = WAIT_READY;
               end else if (!is_write) begin   // Zero-wait read done at once
                  state_d  = WAIT_RREADY;
                  rvalid_d = 1'b1;
               end
            end
         end
         WAIT_READY: begin
            active = 1'b1;
            if (apb_rsp_i.ready) begin
               if (is_write) begin
                  state_d = WAIT_VALID;        // No read data to return
               end else begin
                  state_d  = WAIT_RREADY;
                  rvalid_d = 1'b1;
               end
            end
         end
         default: begin
            // Hold rvalid until the requester takes the data
            if (iob_req_i.rready) begin
               state_d = WAIT_VALID;
            end else begin
               rvalid_d = 1'b1;
            end
         end
      endcase
   end

   assign capture = active & apb_rsp_i.ready & ~is_write;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= WAIT_VALID;
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         state_q  <= state_d;
         rvalid_q <= rvalid_d;
         if (capture) begin
            rdata_q <= apb_rsp_i.rdata;
         end
      end
   end

   // No APB activity while read data waits for the requester
   a_no_enable_in_rready : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (state_q == WAIT_RREADY) |-> !apb_req_o.enable
   ) else $error("APB enable high while waiting for rready");

   a_no_rvalid_after_write : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (apb_rsp_i.ready && apb_req_o.sel && apb_req_o.write) |=> !iob_rsp_o.rvalid
   ) else $error("rvalid raised after a write transfer");

endmodule

`default_nettype wire

//--- design/apb_bridge_pkg.sv
`default_nettype none

`include "apb_bridge_settings.svh"

package apb_bridge_pkg;

   localparam int ADDR_W = `APB_ADDR_W;
   localparam int DATA_W = `APB_DATA_W;
   localparam int STRB_W = DATA_W / 8;   // One strobe per byte lane

   // IOb requester to bridge
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;          // Any bit set means write
      logic              rready;
   } iob_req_t;

   // Bridge back to IOb requester
   typedef struct packed {
      logic              ready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } iob_rsp_t;

   // APB master side request
   typedef struct packed {
      logic              sel;
      logic              enable;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } apb_req_t;

   // APB slave side response
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } apb_rsp_t;

endpackage

`default_nettype wire

//--- design/apb_bridge_settings.svh
`ifndef APB_BRIDGE_SETTINGS_SVH
`define APB_BRIDGE_SETTINGS_SVH

// Bus widths shared by the IOb and APB sides
`define APB_ADDR_W 12
`define APB_DATA_W 32

// Words per register bank
`define REGBANK_DEPTH 16

// Wait states inserted by each bank
`define BANK0_WAIT 0
`define BANK1_WAIT 3

`endif
